//--- design/disc_settings.svh
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// build-time sizing of the sample discriminator
// DISC_CHANNELS must be a power of two, DISC_MAX_DELAY at least 2
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef DISC_SETTINGS_SVH
`define DISC_SETTINGS_SVH

// channels and batch shape
`define DISC_CHANNELS      4
`define DISC_SAMPLE_WIDTH  16
`define DISC_PARALLEL      2

// pre/post-trigger limit, also the delay line depth
`define DISC_MAX_DELAY     15

// output side
`define DISC_FIFO_DEPTH    8
`define DISC_OUT_CREDITS   4
`define DISC_TSTAMP_WIDTH  32

`endif

//--- design/disc_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared types of the discriminator datapath
// samples and thresholds are signed two's complement
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "disc_settings.svh"

package disc_pkg;

  localparam int CHAN_W  = (`DISC_CHANNELS > 1) ? $clog2(`DISC_CHANNELS) : 1;
  localparam int DELAY_W = $clog2(`DISC_MAX_DELAY + 1);

  typedef logic signed [`DISC_SAMPLE_WIDTH-1:0] sample_t;
  typedef sample_t [`DISC_PARALLEL-1:0]         batch_t;
  typedef logic [CHAN_W-1:0]                    chan_idx_t;
  typedef logic [DELAY_W-1:0]                   delay_t;
  typedef logic [`DISC_TSTAMP_WIDTH-1:0]        tstamp_t;

  typedef struct packed {
    batch_t  batch;
    tstamp_t tstamp;
  } stamped_batch_t;

  // disabled channels keep every batch
  typedef struct packed {
    sample_t low_thr;
    sample_t high_thr;
    delay_t  start_delay;
    delay_t  stop_delay;
    logic    disabled;
  } chan_cfg_t;

  typedef struct packed {
    batch_t  batch;
    tstamp_t tstamp;
    logic    seg_start;
  } disc_record_t;

  typedef struct packed {
    chan_idx_t    chan;
    disc_record_t rec;
  } out_beat_t;

endpackage

//--- design/record_fifo.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// first-word-fall-through queue, push when full is dropped
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module record_fifo #(
  parameter type payload_t = logic [7:0],
  parameter int  DEPTH     = 4
) (
  input  logic     adc_clk,
  input  logic     adc_reset,
  input  logic     push_i,
  input  payload_t data_i,
  input  logic     pop_i,
  output payload_t data_o,
  output logic     empty_o,
  output logic     full_o
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  payload_t         mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             do_push;
  logic             do_pop;

  assign full_o  = count_q == CNT_W'(DEPTH);
  assign empty_o = count_q == '0;
  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;
  assign data_o  = mem_q[rd_ptr_q];

  always_ff @(posedge adc_clk) begin
    if (adc_reset) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q <= count_q + CNT_W'(do_push) - CNT_W'(do_pop);
    end
  end

  always_ff @(posedge adc_clk) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

//--- design/disc_ingest.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// config writes apply to batches arriving from the next cycle
// timestamp counts cycles since reset and wraps silently
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "disc_settings.svh"

module disc_ingest import disc_pkg::*; (
  input  logic                                 adc_clk,
  input  logic                                 adc_reset,
  input  logic                                 cfg_we_i,
  input  chan_idx_t                            cfg_chan_i,
  input  chan_cfg_t                            cfg_data_i,
  input  logic                                 adc_valid_i,
  input  batch_t [`DISC_CHANNELS-1:0]          adc_data_i,
  output logic                                 stamped_valid_o,
  output stamped_batch_t [`DISC_CHANNELS-1:0]  stamped_o,
  output chan_cfg_t [`DISC_CHANNELS-1:0]       cfg_o
);

  localparam chan_cfg_t CFG_RESET = '{
    low_thr:     '0,
    high_thr:    '0,
    start_delay: '0,
    stop_delay:  '0,
    disabled:    1'b1
  };

  chan_cfg_t [`DISC_CHANNELS-1:0] cfg_q;
  tstamp_t                        timer_q;

  always_ff @(posedge adc_clk) begin
    if (adc_reset) begin
      timer_q         <= '0;
      stamped_valid_o <= 1'b0;
      for (int ch = 0; ch < `DISC_CHANNELS; ch++) begin
        cfg_q[ch] <= CFG_RESET;
        cfg_o[ch] <= CFG_RESET;
      end
    end else begin
      timer_q         <= timer_q + 1'b1;
      stamped_valid_o <= adc_valid_i;
      if (cfg_we_i) begin
        cfg_q[cfg_chan_i] <= cfg_data_i;
      end
      // second stage lines the config up with the stamped batches
      cfg_o <= cfg_q;
    end
  end

  always_ff @(posedge adc_clk) begin
    if (adc_valid_i) begin
      for (int ch = 0; ch < `DISC_CHANNELS; ch++) begin
        stamped_o[ch] <= '{batch: adc_data_i[ch], tstamp: timer_q};
      end
    end
  end

endmodule

//--- design/channel_discriminator.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// pipeline advances on valid beats only, so the last
// DISC_MAX_DELAY+2 batches wait for later input to be pushed
// change delays or the disable bit only while the input is idle
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "disc_settings.svh"

module channel_discriminator import disc_pkg::*; (
  input  logic           adc_clk,
  input  logic           adc_reset,
  input  logic           valid_i,
  input  stamped_batch_t stamped_i,
  input  chan_cfg_t      cfg_i,
  input  logic           pop_i,
  output disc_record_t   rec_o,
  output logic           empty_o,
  output logic           overflow_o
);

  localparam int D = `DISC_MAX_DELAY;

  typedef struct packed {
    logic           act;
    stamped_batch_t sb;
  } line_entry_t;

  logic         above_hi;
  logic         above_lo;
  logic         act_now;
  logic         active_q;
  delay_t       since_q;
  delay_t       since_next;
  logic         pre_now;
  logic [D:0]   pre_sr_q;
  line_entry_t  eval_q;
  logic         eval_v_q;
  line_entry_t  line_q [D];
  logic [D-1:0] line_v_q;
  line_entry_t  leaving;
  logic         leaving_v;
  logic         pre_hit;
  logic         post_hit;
  delay_t       post_cnt_q;
  logic         keep;
  logic         last_kept_q;
  disc_record_t dec_q;
  logic         dec_keep_q;
  logic         push;
  logic         full;

  // hysteresis on the incoming batch
  always_comb begin
    above_hi = 1'b0;
    above_lo = 1'b0;
    for (int i = 0; i < `DISC_PARALLEL; i++) begin
      if (stamped_i.batch[i] > cfg_i.high_thr) begin
        above_hi = 1'b1;
      end
      if (stamped_i.batch[i] > cfg_i.low_thr) begin
        above_lo = 1'b1;
      end
    end
    act_now = (above_hi | active_q) & above_lo;
  end

  // beats since the last active batch, saturating at D
  assign since_next = act_now ? '0 : ((since_q == delay_t'(D)) ? since_q : since_q + 1'b1);
  // an active batch lies within start_delay beats after the batch start_delay ago
  assign pre_now    = since_next < cfg_i.start_delay;

  assign leaving   = line_q[D-1];
  assign leaving_v = line_v_q[D-1];
  // tap D-start_delay holds the flag taken start_delay beats after the leaving batch
  assign pre_hit   = pre_sr_q[D - int'(cfg_i.start_delay)];
  assign post_hit  = post_cnt_q != '0;
  assign keep      = leaving_v & (cfg_i.disabled | leaving.act | pre_hit | post_hit);
  assign push      = valid_i & dec_keep_q;

  always_ff @(posedge adc_clk) begin
    if (adc_reset) begin
      active_q    <= 1'b0;
      since_q     <= delay_t'(D);
      pre_sr_q    <= '0;
      eval_v_q    <= 1'b0;
      line_v_q    <= '0;
      post_cnt_q  <= '0;
      last_kept_q <= 1'b0;
      dec_keep_q  <= 1'b0;
      overflow_o  <= 1'b0;
    end else begin
      if (valid_i) begin
        active_q   <= act_now;
        since_q    <= since_next;
        pre_sr_q   <= {pre_sr_q[D-1:0], pre_now};
        eval_v_q   <= 1'b1;
        line_v_q   <= {line_v_q[D-2:0], eval_v_q};
        dec_keep_q <= keep;
        if (leaving_v) begin
          last_kept_q <= keep;
          post_cnt_q  <= leaving.act ? cfg_i.stop_delay :
                         (post_hit ? post_cnt_q - 1'b1 : '0);
        end
      end
      if (push && full) begin
        overflow_o <= 1'b1;
      end
    end
  end

  always_ff @(posedge adc_clk) begin
    if (valid_i) begin
      eval_q    <= '{act: act_now, sb: stamped_i};
      line_q[0] <= eval_q;
      for (int k = 1; k < D; k++) begin
        line_q[k] <= line_q[k-1];
      end
      dec_q <= '{
        batch:     leaving.sb.batch,
        tstamp:    leaving.sb.tstamp,
        seg_start: ~last_kept_q
      };
    end
  end

  record_fifo #(
    .payload_t (disc_record_t),
    .DEPTH     (`DISC_FIFO_DEPTH)
  ) u_rec_fifo (
    .adc_clk   (adc_clk),
    .adc_reset (adc_reset),
    .push_i    (push),
    .data_i    (dec_q),
    .pop_i     (pop_i),
    .data_o    (rec_o),
    .empty_o   (empty_o),
    .full_o    (full)
  );

endmodule

//--- design/record_arbiter.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// one record per cycle, round robin, only while a credit is held
// the sink returns at most one credit per cycle per beat received
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "disc_settings.svh"

module record_arbiter import disc_pkg::*; (
  input  logic                               adc_clk,
  input  logic                               adc_reset,
  input  disc_record_t [`DISC_CHANNELS-1:0]  rec_i,
  input  logic [`DISC_CHANNELS-1:0]          empty_i,
  input  logic                               out_credit_i,
  output logic [`DISC_CHANNELS-1:0]          pop_o,
  output logic                               out_valid_o,
  output out_beat_t                          out_beat_o
);

  localparam int N        = `DISC_CHANNELS;
  localparam int CREDIT_W = $clog2(`DISC_OUT_CREDITS + 1);

  chan_idx_t           rr_q;
  chan_idx_t           sel;
  logic                found;
  logic                move;
  logic [CREDIT_W-1:0] credits_q;
  out_beat_t           stage_beat;
  logic                out_empty;

  // first non-empty queue after the one served last
  always_comb begin : pick
    int idx;
    sel   = rr_q;
    found = 1'b0;
    for (int off = 1; off <= N; off++) begin
      idx = (int'(rr_q) + off) % N;
      if (!found && !empty_i[idx]) begin
        found = 1'b1;
        sel   = chan_idx_t'(idx);
      end
    end
  end

  assign move       = found & (credits_q != '0);
  assign stage_beat = '{chan: sel, rec: rec_i[sel]};

  always_comb begin
    pop_o = '0;
    if (move) begin
      pop_o[sel] = 1'b1;
    end
  end

  always_ff @(posedge adc_clk) begin
    if (adc_reset) begin
      rr_q      <= chan_idx_t'(N - 1);
      credits_q <= CREDIT_W'(`DISC_OUT_CREDITS);
    end else begin
      if (move) begin
        rr_q <= sel;
      end
      // credit is spent when the record moves, not when it leaves
      credits_q <= credits_q - CREDIT_W'(move) + CREDIT_W'(out_credit_i);
    end
  end

  // each beat spends exactly one cycle at the head before it goes
  assign out_valid_o = ~out_empty;

  record_fifo #(
    .payload_t (out_beat_t),
    .DEPTH     (2)
  ) u_out_fifo (
    .adc_clk   (adc_clk),
    .adc_reset (adc_reset),
    .push_i    (move),
    .data_i    (stage_beat),
    .pop_i     (out_valid_o),
    .data_o    (out_beat_o),
    .empty_o   (out_empty),
    .full_o    ()
  );

endmodule

//--- design/sample_discriminator_top.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ADC input cannot stall; records drop at a full channel queue
// overflow_o bits are sticky until reset
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "disc_settings.svh"

module sample_discriminator_top import disc_pkg::*; (
  input  logic                         adc_clk,
  input  logic                         adc_reset,
  input  logic                         cfg_we_i,
  input  chan_idx_t                    cfg_chan_i,
  input  chan_cfg_t                    cfg_data_i,
  input  logic                         adc_valid_i,
  input  batch_t [`DISC_CHANNELS-1:0]  adc_data_i,
  input  logic                         out_credit_i,
  output logic                         out_valid_o,
  output out_beat_t                    out_beat_o,
  output logic [`DISC_CHANNELS-1:0]    overflow_o
);

  logic                                stamped_valid;
  stamped_batch_t [`DISC_CHANNELS-1:0] stamped;
  chan_cfg_t [`DISC_CHANNELS-1:0]      cfg;
  disc_record_t [`DISC_CHANNELS-1:0]   rec;
  logic [`DISC_CHANNELS-1:0]           empty;
  logic [`DISC_CHANNELS-1:0]           pop;

  disc_ingest u_ingest (
    .adc_clk         (adc_clk),
    .adc_reset       (adc_reset),
    .cfg_we_i        (cfg_we_i),
    .cfg_chan_i      (cfg_chan_i),
    .cfg_data_i      (cfg_data_i),
    .adc_valid_i     (adc_valid_i),
    .adc_data_i      (adc_data_i),
    .stamped_valid_o (stamped_valid),
    .stamped_o       (stamped),
    .cfg_o           (cfg)
  );

  for (genvar ch = 0; ch < `DISC_CHANNELS; ch++) begin : g_chan
    channel_discriminator u_disc (
      .adc_clk    (adc_clk),
      .adc_reset  (adc_reset),
      .valid_i    (stamped_valid),
      .stamped_i  (stamped[ch]),
      .cfg_i      (cfg[ch]),
      .pop_i      (pop[ch]),
      .rec_o      (rec[ch]),
      .empty_o    (empty[ch]),
      .overflow_o (overflow_o[ch])
    );
  end

  record_arbiter u_arbiter (
    .adc_clk      (adc_clk),
    .adc_reset    (adc_reset),
    .rec_i        (rec),
    .empty_i      (empty),
    .out_credit_i (out_credit_i),
    .pop_o        (pop),
    .out_valid_o  (out_valid_o),
    .out_beat_o   (out_beat_o)
  );

endmodule

//--- tb/sample_discriminator_chk.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bound to sample_discriminator_top, watches credits and overflow
// assumes the sink returns at most one credit per cycle
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "disc_settings.svh"

module sample_discriminator_chk (
  input logic                      adc_clk,
  input logic                      adc_reset,
  input logic                      out_valid_o,
  input logic                      out_credit_i,
  input logic [`DISC_CHANNELS-1:0] overflow_o
);

  // beats delivered and not yet paid back
  int outstanding;

  always_ff @(posedge adc_clk) begin
    if (adc_reset) begin
      outstanding <= 0;
    end else begin
      outstanding <= outstanding + int'(out_valid_o) - int'(out_credit_i);
    end
  end

  credit_limit: assert property (@(posedge adc_clk) disable iff (adc_reset)
    out_valid_o |-> (outstanding < `DISC_OUT_CREDITS))
    else $error("beat sent without a credit");

  quiet_in_reset: assert property (@(posedge adc_clk)
    (adc_reset && $past(adc_reset)) |-> !out_valid_o)
    else $error("out_valid_o high during reset");

  overflow_sticky: assert property (@(posedge adc_clk)
    (!adc_reset && !$past(adc_reset)) |-> ((overflow_o & $past(overflow_o)) == $past(overflow_o)))
    else $error("overflow bit fell without reset");

endmodule

//--- tb/sample_discriminator_tb.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// each test starts from reset, so the last DISC_MAX_DELAY+2
// batches of a test stay in the pipeline and are not expected
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "disc_settings.svh"

module sample_discriminator_tb import disc_pkg::*; ();

  localparam int CH          = `DISC_CHANNELS;
  localparam int TAIL        = `DISC_MAX_DELAY + 2;
  localparam int MAX_LOG     = 128;
  localparam int TEST_BUDGET = 8 + 16 + 77 * 4 + 160;
  localparam int TIMEOUT     = 6 * TEST_BUDGET + 200;

  logic                adc_clk;
  logic                adc_reset;
  logic                cfg_we_i;
  chan_idx_t           cfg_chan_i;
  chan_cfg_t           cfg_data_i;
  logic                adc_valid_i;
  batch_t [CH-1:0]     adc_data_i;
  logic                out_credit_i;
  logic                out_valid_o;
  out_beat_t           out_beat_o;
  logic [CH-1:0]       overflow_o;

  int          seed;
  int          tick;
  int          cyc;
  int          last_beat;
  int          hold_until;
  int          sink_delay;
  int          due_q[$];
  int          err_value;
  int          err_other;
  logic        ovf_mode;
  logic        compare_busy;
  event        compare_req;

  // stream log and config shadow
  batch_t       log_batch [MAX_LOG][CH];
  sample_t      log_lo [MAX_LOG][CH];
  sample_t      log_hi [MAX_LOG][CH];
  tstamp_t      log_ts [MAX_LOG];
  int           log_n;
  sample_t      cur_lo [CH];
  sample_t      cur_hi [CH];
  int           cur_sd [CH];
  int           cur_pd [CH];
  logic         cur_dis [CH];
  disc_record_t exp_q [CH][$];
  disc_record_t got_q [CH][$];

  sample_discriminator_top u_dut (
    .adc_clk      (adc_clk),
    .adc_reset    (adc_reset),
    .cfg_we_i     (cfg_we_i),
    .cfg_chan_i   (cfg_chan_i),
    .cfg_data_i   (cfg_data_i),
    .adc_valid_i  (adc_valid_i),
    .adc_data_i   (adc_data_i),
    .out_credit_i (out_credit_i),
    .out_valid_o  (out_valid_o),
    .out_beat_o   (out_beat_o),
    .overflow_o   (overflow_o)
  );

  bind sample_discriminator_top sample_discriminator_chk u_chk (
    .adc_clk      (adc_clk),
    .adc_reset    (adc_reset),
    .out_valid_o  (out_valid_o),
    .out_credit_i (out_credit_i),
    .overflow_o   (overflow_o)
  );

  initial begin
    adc_clk = 1'b0;
    forever #20 adc_clk = ~adc_clk;
  end

  // cycle counters and the run limit
  always @(posedge adc_clk) begin
    tick <= tick + 1;
    if (adc_reset) begin
      cyc <= 0;
    end else begin
      cyc <= cyc + 1;
    end
    if (tick >= TIMEOUT) begin
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  // collect beats and schedule their credits
  always @(posedge adc_clk) begin
    if (!adc_reset && out_valid_o) begin
      got_q[out_beat_o.chan].push_back(out_beat_o.rec);
      due_q.push_back(tick + sink_delay);
      last_beat = tick;
    end
  end

  always begin
    @(posedge adc_clk);
    #2;
    out_credit_i = 1'b0;
    if (due_q.size() > 0 && tick >= hold_until) begin
      if (due_q[0] <= tick) begin
        void'(due_q.pop_front());
        out_credit_i = 1'b1;
      end
    end
  end

  // expected records of one channel from the logged stream
  function automatic void build_expected(int ch);
    logic         act [MAX_LOG];
    logic         keep [MAX_LOG];
    logic         prev_act;
    logic         hi_hit;
    logic         lo_hit;
    disc_record_t rec;
    exp_q[ch].delete();
    prev_act = 1'b0;
    for (int j = 0; j < log_n; j++) begin
      hi_hit = 1'b0;
      lo_hit = 1'b0;
      for (int i = 0; i < `DISC_PARALLEL; i++) begin
        if (log_batch[j][ch][i] > log_hi[j][ch]) hi_hit = 1'b1;
        if (log_batch[j][ch][i] > log_lo[j][ch]) lo_hit = 1'b1;
      end
      act[j] = (hi_hit || prev_act) && lo_hit;
      prev_act = act[j];
    end
    for (int j = 0; j < log_n; j++) begin
      keep[j] = cur_dis[ch] || act[j];
      for (int k = 1; k <= cur_sd[ch]; k++) begin
        if (j + k < log_n && act[j+k]) keep[j] = 1'b1;
      end
      for (int k = 1; k <= cur_pd[ch]; k++) begin
        if (j - k >= 0 && act[j-k]) keep[j] = 1'b1;
      end
    end
    for (int j = 0; j < log_n - TAIL; j++) begin
      if (keep[j]) begin
        rec.batch  = log_batch[j][ch];
        rec.tstamp = log_ts[j];
        if (j == 0) begin
          rec.seg_start = 1'b1;
        end else begin
          rec.seg_start = !keep[j-1];
        end
        exp_q[ch].push_back(rec);
      end
    end
  endfunction

  // compares collected beats with the expected queues
  always begin
    int idx;
    @(compare_req);
    for (int ch = 0; ch < CH; ch++) begin
      if (ovf_mode) begin
        idx = 0;
        for (int g = 0; g < got_q[ch].size(); g++) begin
          while (idx < exp_q[ch].size() && exp_q[ch][idx] != got_q[ch][g]) idx++;
          if (idx == exp_q[ch].size()) begin
            $display("channel %0d delivered a record out of order or unknown", ch);
            err_other++;
            break;
          end
          if (g < `DISC_FIFO_DEPTH + `DISC_OUT_CREDITS && idx != g) begin
            $display("channel %0d lost record %0d before its queue was full", ch, g);
            err_other++;
          end
          idx++;
        end
      end else begin
        if (got_q[ch].size() != exp_q[ch].size()) begin
          $display("FAILED out_beat_o count ch%0d: got %h expected %h",
                   ch, got_q[ch].size(), exp_q[ch].size());
          err_value++;
        end
        for (int g = 0; g < got_q[ch].size() && g < exp_q[ch].size(); g++) begin
          if (got_q[ch][g].batch != exp_q[ch][g].batch) begin
            $display("FAILED out_beat_o.rec.batch ch%0d #%0d: got %h expected %h",
                     ch, g, got_q[ch][g].batch, exp_q[ch][g].batch);
            err_value++;
          end
          if (got_q[ch][g].tstamp != exp_q[ch][g].tstamp) begin
            $display("FAILED out_beat_o.rec.tstamp ch%0d #%0d: got %h expected %h",
                     ch, g, got_q[ch][g].tstamp, exp_q[ch][g].tstamp);
            err_value++;
          end
          if (got_q[ch][g].seg_start != exp_q[ch][g].seg_start) begin
            $display("FAILED out_beat_o.rec.seg_start ch%0d #%0d: got %h expected %h",
                     ch, g, got_q[ch][g].seg_start, exp_q[ch][g].seg_start);
            err_value++;
          end
        end
      end
    end
    compare_busy = 1'b0;
  end

  task automatic reset_dut();
    @(posedge adc_clk);
    #2;
    adc_reset = 1'b1;
    repeat (8) @(posedge adc_clk);
    #2;
    adc_reset = 1'b0;
    log_n = 0;
    hold_until = 0;
    due_q.delete();
    for (int ch = 0; ch < CH; ch++) begin
      got_q[ch].delete();
      cur_lo[ch] = '0;
      cur_hi[ch] = '0;
      cur_sd[ch] = 0;
      cur_pd[ch] = 0;
      cur_dis[ch] = 1'b1;
    end
  endtask

  task automatic set_cfg(input int ch, input int lo, input int hi, input int sd,
                         input int pd, input logic dis);
    @(posedge adc_clk);
    #2;
    adc_valid_i = 1'b0;
    cfg_we_i    = 1'b1;
    cfg_chan_i  = chan_idx_t'(ch);
    cfg_data_i  = '{low_thr: sample_t'(lo), high_thr: sample_t'(hi),
                    start_delay: delay_t'(sd), stop_delay: delay_t'(pd), disabled: dis};
    cur_lo[ch]  = sample_t'(lo);
    cur_hi[ch]  = sample_t'(hi);
    cur_sd[ch]  = sd;
    cur_pd[ch]  = pd;
    cur_dis[ch] = dis;
  endtask

  // mode 0 every cycle, 1 every fourth cycle, 2 random gaps
  task automatic drive_stream(input int n, input int mode);
    int   sent;
    int   k;
    logic v;
    sent = 0;
    k = 0;
    while (sent < n) begin
      @(posedge adc_clk);
      #2;
      cfg_we_i = 1'b0;
      case (mode)
        0:       v = 1'b1;
        1:       v = (k % 4) == 0;
        default: v = ($random(seed) % 2) != 0;
      endcase
      adc_valid_i = v;
      if (v) begin
        log_ts[log_n] = tstamp_t'(cyc);
        for (int ch = 0; ch < CH; ch++) begin
          for (int i = 0; i < `DISC_PARALLEL; i++) begin
            adc_data_i[ch][i] = sample_t'($random(seed) % 1000);
          end
          log_batch[log_n][ch] = adc_data_i[ch];
          log_lo[log_n][ch] = cur_lo[ch];
          log_hi[log_n][ch] = cur_hi[ch];
        end
        log_n++;
        sent++;
      end
      k++;
    end
    @(posedge adc_clk);
    #2;
    adc_valid_i = 1'b0;
  endtask

  // drain, then compare; ovf_ch < 0 means no overflow is allowed
  task automatic finish_test(input int ovf_ch);
    while (!(tick >= hold_until && due_q.size() == 0 && tick - last_beat > 40)) begin
      @(posedge adc_clk);
    end
    for (int ch = 0; ch < CH; ch++) begin
      build_expected(ch);
    end
    ovf_mode = ovf_ch >= 0;
    compare_busy = 1'b1;
    ->compare_req;
    wait (!compare_busy);
    if (ovf_ch < 0 && overflow_o != '0) begin
      $display("unexpected overflow, flags %h", overflow_o);
      err_other++;
    end
    if (ovf_ch >= 0 && !overflow_o[ovf_ch]) begin
      $display("overflow flag of channel %0d did not set", ovf_ch);
      err_other++;
    end
    if (ovf_ch >= 0 && got_q[ovf_ch].size() <= `DISC_FIFO_DEPTH + `DISC_OUT_CREDITS) begin
      $display("no records delivered after the overflow on channel %0d", ovf_ch);
      err_other++;
    end
  endtask

  task automatic set_off(input int ch);
    set_cfg(ch, 32767, 32767, 0, 0, 1'b0);
  endtask

  initial begin
    seed = 26;
    tick = 0;
    cyc = 0;
    last_beat = 0;
    hold_until = 0;
    sink_delay = 1;
    err_value = 0;
    err_other = 0;
    ovf_mode = 1'b0;
    compare_busy = 1'b0;
    log_n = 0;
    adc_reset = 1'b1;
    cfg_we_i = 1'b0;
    cfg_chan_i = '0;
    cfg_data_i = '0;
    adc_valid_i = 1'b0;
    adc_data_i = '0;
    out_credit_i = 1'b0;

    // hysteresis, no windows
    reset_dut();
    set_cfg(0, 200, 600, 0, 0, 1'b0);
    set_cfg(1, -100, 300, 0, 0, 1'b0);
    set_off(2);
    set_off(3);
    drive_stream(77, 1);
    finish_test(-1);

    // pre and post windows
    reset_dut();
    set_cfg(0, 200, 700, 3, 0, 1'b0);
    set_cfg(1, 200, 700, 0, 4, 1'b0);
    set_cfg(2, 300, 800, 2, 5, 1'b0);
    set_off(3);
    drive_stream(77, 1);
    finish_test(-1);

    // disabled channel with input gaps
    reset_dut();
    sink_delay = 3;
    set_off(0);
    set_off(1);
    set_off(3);
    drive_stream(67, 2);
    finish_test(-1);

    // threshold change mid-stream
    reset_dut();
    sink_delay = 1;
    set_off(0);
    set_cfg(1, 200, 600, 0, 0, 1'b0);
    set_off(2);
    set_off(3);
    drive_stream(30, 1);
    set_cfg(1, -300, 100, 0, 0, 1'b0);
    drive_stream(47, 1);
    finish_test(-1);

    // credits withheld, burst fits
    reset_dut();
    sink_delay = 0;
    set_off(1);
    set_off(2);
    set_off(3);
    hold_until = tick + 100;
    drive_stream(27, 0);
    finish_test(-1);

    // credits withheld, queue overflows
    reset_dut();
    set_off(0);
    set_off(1);
    set_off(2);
    hold_until = tick + 45;
    drive_stream(77, 0);
    finish_test(3);

    $display("errors: value %0d, other %0d", err_value, err_other);
    if (err_value == 0 && err_other == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

//--- vlog.f
+incdir+design
design/disc_pkg.sv
design/record_fifo.sv
design/disc_ingest.sv
design/channel_discriminator.sv
design/record_arbiter.sv
design/sample_discriminator_top.sv
tb/sample_discriminator_chk.sv
tb/sample_discriminator_tb.sv

//--- run_sim.sh
#!/bin/sh
# compile with Verilator, run, then judge the run from its log
rm -f sim.log
verilator --binary --timing --assert -f vlog.f \
  --top-module sample_discriminator_tb -o simv > build.log 2>&1 &&
./obj_dir/simv > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "TESTBENCH PASSED" sim.log 2>/dev/null && echo "simulation ok" || {
  echo "simulation failed, see build.log and sim.log"
  exit 1
}
